// File: vlog.f
+incdir+.
histPkg.sv
acqWindow.sv
hisBuilder.sv
peakTracker.sv
histogramTop.sv
histogramTb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = histogramTb
FILELIST = vlog.f
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: histogramTb.sv
`include "histogram_config.svh"

module histogramTb import histPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int resetCycles = 16;
    localparam int numWindows  = 10;
    localparam int cycleLimit  = resetCycles + (numWindows + 2) * `ACQ_LEN + 216;
    localparam int seed        = 67499;

    localparam int tReset  = 0;
    localparam int tWindow = 1;
    localparam int tCount  = 2;
    localparam int tBack   = 3;
    localparam int tLazy   = 4;
    localparam int tPeak   = 5;

    string testName [6] = '{"reset", "window", "count", "backToBack", "lazyClear", "peak"};
    int    errCnt [6];
    int    passCnt;
    int    failCnt;
    int    cycles;
    int    hitTest; // test that owns the current stimulus
    int    runLeft; // hits left in the current run on one bin
    binAddrT runBin;

    logic     clk;
    logic     res;
    logic     hitValid;
    binAddrT  hitBin;
    logic     nextFlag;
    pixelIdxT pixelIdx;
    logic     countValid;
    binAddrT  countBin;
    countT    binCounts;
    logic     peakValid;
    binAddrT  peakBin;
    countT    peakCount;
    pixelIdxT peakPixel;

    // reference model
    countT    mBins [`PIXEL_NUM][`BIN_NUM];
    int       mCnt;  // cycle within the window
    pixelIdxT mPix;
    logic     mFlag;
    countT    mMax;  // running peak
    binAddrT  mMaxBin;
    logic     eCountValid;
    binAddrT  eCountBin;
    countT    eCount;
    logic     ePeakValid;
    binAddrT  ePeakBin;
    countT    ePeakCount;
    pixelIdxT ePeakPixel;

    histogramTop i_dut (
        .clk        (clk),
        .res        (res),
        .hitValid   (hitValid),
        .hitBin     (hitBin),
        .nextFlag   (nextFlag),
        .pixelIdx   (pixelIdx),
        .countValid (countValid),
        .countBin   (countBin),
        .binCounts  (binCounts),
        .peakValid  (peakValid),
        .peakBin    (peakBin),
        .peakCount  (peakCount),
        .peakPixel  (peakPixel)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < cycleLimit) begin
            @(posedge clk);
            cycles++;
        end
        $display("run did not finish within %0d cycles", cycleLimit);
        $display("TB FAILED");
        $finish;
    end

    // pixel index and toggle flag move on the same edge
    windowStep: assert property (@(posedge clk) disable iff (!res)
            (nextFlag != $past(nextFlag)) == (pixelIdx != $past(pixelIdx)))
        else begin
            $display("Error window: nextFlag and pixelIdx did not change on the same edge");
            errCnt[tWindow]++;
        end

    task automatic reportMismatch(input int t, input string what,
                                  input logic [31:0] expV, input logic [31:0] actV);
        $display("Error %s: %s expected %0d, got %0d", testName[t], what, expV, actV);
        errCnt[t]++;
    endtask

    task automatic checkIdle();
        assert (countValid === 1'b0) else reportMismatch(tReset, "countValid", 0, countValid);
        assert (peakValid === 1'b0) else reportMismatch(tReset, "peakValid", 0, peakValid);
        assert (nextFlag === 1'b0) else reportMismatch(tReset, "nextFlag", 0, nextFlag);
        assert (pixelIdx === '0) else reportMismatch(tReset, "pixelIdx", 0, pixelIdx);
    endtask

    task automatic checkOutputs(input int t);
        assert (countValid === eCountValid)
            else reportMismatch(t, "countValid", eCountValid, countValid);
        if (eCountValid) begin
            assert (countBin === eCountBin) else reportMismatch(t, "countBin", eCountBin, countBin);
            assert (binCounts === eCount) else reportMismatch(t, "binCounts", eCount, binCounts);
        end
        assert (pixelIdx === mPix) else reportMismatch(tWindow, "pixelIdx", mPix, pixelIdx);
        assert (nextFlag === mFlag) else reportMismatch(tWindow, "nextFlag", mFlag, nextFlag);
        assert (peakValid === ePeakValid)
            else reportMismatch(tPeak, "peakValid", ePeakValid, peakValid);
        if (ePeakValid) begin
            assert (peakPixel === ePeakPixel)
                else reportMismatch(tPeak, "peakPixel", ePeakPixel, peakPixel);
            assert (peakBin === ePeakBin) else reportMismatch(tPeak, "peakBin", ePeakBin, peakBin);
            assert (peakCount === ePeakCount)
                else reportMismatch(tPeak, "peakCount", ePeakCount, peakCount);
        end
    endtask

    // what the DUT should show after the coming rising edge
    task automatic stepModel(input logic hit, input binAddrT bin);
        logic  wEnd;
        countT nc;
        wEnd = (mCnt == `ACQ_LEN - 1);
        if (mCnt == 0) begin
            for (int b = 0; b < `BIN_NUM; b++) begin
                mBins[mPix][b] = '0; // new window starts from empty bins
            end
        end
        eCountValid = hit && !wEnd;
        ePeakValid  = wEnd;
        if (eCountValid) begin
            nc = mBins[mPix][bin];
            if (nc != '1) begin
                nc = nc + 1'b1;
            end
            mBins[mPix][bin] = nc;
            eCountBin = bin;
            eCount    = nc;
            if (nc > mMax) begin // first bin to reach a count keeps it
                mMax    = nc;
                mMaxBin = bin;
            end
        end
        if (wEnd) begin
            ePeakBin   = mMaxBin;
            ePeakCount = mMax;
            ePeakPixel = mPix;
            mMax       = '0;
            mMaxBin    = '0;
            mCnt       = 0;
            mPix       = (mPix == pixelIdxT'(`PIXEL_NUM - 1)) ? '0 : mPix + 1'b1;
            mFlag      = ~mFlag;
        end else begin
            mCnt++;
        end
    endtask

    task automatic pickHit(input int w, output logic hit, output binAddrT bin);
        case (hitTest)
            tBack: begin
                if (runLeft == 0) begin
                    runBin  = binAddrT'($urandom_range(0, `BIN_NUM - 1));
                    runLeft = (mCnt < 8) ? 40 : $urandom_range(2, 8); // one long run first
                end
                runLeft--;
                hit = 1'b1;
                bin = runBin;
            end
            tPeak: begin
                if (w == numWindows - 1) begin
                    // bins 0 and 1 take turns and end on the same count
                    hit = (mCnt < `ACQ_LEN - 2);
                    bin = binAddrT'(mCnt % 2);
                end else begin
                    hit = (w != 7) && ($urandom_range(0, 1) == 1); // window 7 stays empty
                    bin = binAddrT'($urandom_range(0, 3));         // few bins so ties happen
                end
            end
            default: begin
                hit = ($urandom_range(0, 1) == 1) || (mCnt == `ACQ_LEN - 1);
                bin = binAddrT'($urandom_range(0, `BIN_NUM - 1));
            end
        endcase
    endtask

    task automatic printResult(input int t);
        if (errCnt[t] == 0) begin
            $display("test %s: pass", testName[t]);
            passCnt++;
        end else begin
            $display("test %s: fail with %0d errors", testName[t], errCnt[t]);
            failCnt++;
        end
    endtask

    initial begin
        int      winNo;
        logic    hit;
        logic    lastOfWin;
        binAddrT bin;
        void'($urandom(seed));
        res      = 1'b0;
        hitValid = 1'b0;
        hitBin   = '0;
        passCnt  = 0;
        failCnt  = 0;
        runLeft  = 0;
        runBin   = '0;
        foreach (mBins[p, b]) mBins[p][b] = '0;
        mPix        = '0;
        mFlag       = 1'b0;
        mMax        = '0;
        mMaxBin     = '0;
        eCountValid = 1'b0;
        ePeakValid  = 1'b0;
        for (int i = 0; i < resetCycles; i++) begin
            @(negedge clk);
            checkIdle();
        end
        res = 1'b1;
        @(negedge clk);
        checkIdle(); // first cycle after release with no hit driven
        printResult(tReset);
        mCnt  = 1;
        winNo = 0;
        while (winNo < numWindows) begin
            if (winNo < 4) hitTest = tCount;
            else if (winNo < 6) hitTest = tLazy; // pixels 0 and 1 revisited
            else if (winNo == 6) hitTest = tBack;
            else hitTest = tPeak;
            pickHit(winNo, hit, bin);
            hitValid  = hit;
            hitBin    = bin;
            lastOfWin = (mCnt == `ACQ_LEN - 1);
            stepModel(hit, bin);
            @(negedge clk);
            checkOutputs(hitTest);
            if (lastOfWin) begin
                winNo++;
                if (winNo == 4) printResult(tCount);
                if (winNo == 6) printResult(tLazy);
                if (winNo == 7) printResult(tBack);
            end
        end
        hitValid = 1'b0;
        printResult(tWindow);
        printResult(tPeak);
        $display("tests passed %0d, failed %0d", passCnt, failCnt);
        if (failCnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: histogramTop.sv
`include "histogram_config.svh"

module histogramTop import histPkg::*; (
    input  logic     clk,
    input  logic     res,
    input  logic     hitValid,
    input  binAddrT  hitBin,
    output logic     nextFlag,
    output pixelIdxT pixelIdx,
    output logic     countValid,
    output binAddrT  countBin,
    output countT    binCounts,
    output logic     peakValid,
    output binAddrT  peakBin,
    output countT    peakCount,
    output pixelIdxT peakPixel
);

    logic windowEnd; // last cycle of the current pixel window

    acqWindow iAcqWindow (
        .clk       (clk),
        .res       (res),
        .windowEnd (windowEnd),
        .pixelIdx  (pixelIdx),
        .nextFlag  (nextFlag)
    );

    hisBuilder iHisBuilder (
        .clk        (clk),
        .res        (res),
        .hitValid   (hitValid),
        .hitBin     (hitBin),
        .pixelIdx   (pixelIdx),
        .windowEnd  (windowEnd),
        .countValid (countValid),
        .countBin   (countBin),
        .binCounts  (binCounts)
    );

    // watches the same updates that leave the top
    peakTracker iPeakTracker (
        .clk        (clk),
        .res        (res),
        .countValid (countValid),
        .countBin   (countBin),
        .binCounts  (binCounts),
        .windowEnd  (windowEnd),
        .pixelIdx   (pixelIdx),
        .peakValid  (peakValid),
        .peakBin    (peakBin),
        .peakCount  (peakCount),
        .peakPixel  (peakPixel)
    );

endmodule

// File: peakTracker.sv
`include "histogram_config.svh"

module peakTracker import histPkg::*; (
    input  logic     clk,
    input  logic     res,
    input  logic     countValid,
    input  binAddrT  countBin,
    input  countT    binCounts,
    input  logic     windowEnd,
    input  pixelIdxT pixelIdx,
    output logic     peakValid,
    output binAddrT  peakBin,
    output countT    peakCount,
    output pixelIdxT peakPixel
);

    countT   maxCount; // running maximum of this window
    binAddrT maxBin;
    logic    takeNew;
    countT   curCount;
    binAddrT curBin;

    // strictly greater only, so on a tie the earlier bin stays
    assign takeNew  = countValid && (binCounts > maxCount);
    assign curCount = takeNew ? binCounts : maxCount;
    assign curBin   = takeNew ? countBin : maxBin;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            peakValid <= 1'b0;
            maxCount  <= '0;
            maxBin    <= '0;
        end else begin
            peakValid <= windowEnd;
            if (windowEnd) begin
                maxCount <= '0; // next window starts empty
                maxBin   <= '0;
            end else begin
                maxCount <= curCount;
                maxBin   <= curBin;
            end
        end
    end

    // result includes the update of the closing cycle
    always_ff @(posedge clk) begin
        if (windowEnd) begin
            peakCount <= curCount;
            peakBin   <= curBin;
            peakPixel <= pixelIdx; // pixel of the window just closed
        end
    end

endmodule

// File: hisBuilder.sv
`include "histogram_config.svh"

module hisBuilder import histPkg::*; (
    input  logic     clk,
    input  logic     res,
    input  logic     hitValid,
    input  binAddrT  hitBin,
    input  pixelIdxT pixelIdx,
    input  logic     windowEnd,
    output logic     countValid,
    output binAddrT  countBin,
    output countT    binCounts
);

    localparam int memWords = `PIXEL_NUM * `BIN_NUM;
    localparam int addrW    = `PIXEL_W + `BIN_W;

    countT              mem [memWords]; // bin counts, pixel major
    logic [memWords-1:0] touched;       // word holds a count of the current round
    logic               winOpen;        // first cycle of a window
    logic               accept;
    logic [addrW-1:0]   hitAddr;
    logic [addrW-1:0]   wrAddr;         // address of the registered update
    countT              baseCount;
    countT              newCount;

    // hits on the closing cycle belong to no window
    assign accept  = hitValid && !windowEnd;
    assign hitAddr = {pixelIdx, hitBin};

    // previous count of the hit bin
    always_comb begin
        if (winOpen) begin
            baseCount = '0; // touched bits of this pixel go away this cycle
        end else if (countValid && (wrAddr == hitAddr)) begin
            baseCount = binCounts; // still on its way into the memory
        end else if (touched[hitAddr]) begin
            baseCount = mem[hitAddr];
        end else begin
            baseCount = '0; // stale from an earlier round
        end
    end

    // saturating increment
    assign newCount = (baseCount == '1) ? baseCount : baseCount + 1'b1;

    // window opens after reset and after every windowEnd
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            winOpen <= 1'b1;
        end else begin
            winOpen <= windowEnd;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            countValid <= 1'b0;
            touched    <= '0;
        end else begin
            countValid <= accept;
            if (winOpen) begin
                // lazy clear of the new pixel
                for (int b = 0; b < `BIN_NUM; b++) begin
                    touched[{pixelIdx, binAddrT'(b)}] <= 1'b0;
                end
            end
            if (countValid) begin
                touched[wrAddr] <= 1'b1; // marks the word written below
            end
        end
    end

    // update registers, then write back one cycle later
    always_ff @(posedge clk) begin
        if (accept) begin
            countBin  <= hitBin;
            binCounts <= newCount;
            wrAddr    <= hitAddr;
        end
        if (countValid) begin
            mem[wrAddr] <= binCounts;
        end
    end

endmodule

// File: acqWindow.sv
`include "histogram_config.svh"

module acqWindow import histPkg::*; (
    input  logic     clk,
    input  logic     res,
    output logic     windowEnd,
    output pixelIdxT pixelIdx,
    output logic     nextFlag
);

    acqCntT acqCnt; // cycle within current window

    // last cycle of the window, straight from the counter
    assign windowEnd = (acqCnt == acqCntT'(`ACQ_LEN - 1));

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            acqCnt   <= '0;
            pixelIdx <= '0;
            nextFlag <= 1'b0;
        end else if (windowEnd) begin
            acqCnt   <= '0;
            nextFlag <= ~nextFlag; // one toggle per closed window
            if (pixelIdx == pixelIdxT'(`PIXEL_NUM - 1)) begin
                pixelIdx <= '0; // wrap over the pixel array
            end else begin
                pixelIdx <= pixelIdx + 1'b1;
            end
        end else begin
            acqCnt <= acqCnt + 1'b1;
        end
    end

endmodule

// File: histPkg.sv
`include "histogram_config.svh"

package histPkg;

    // hit bin code from the front end
    typedef logic [`BIN_W-1:0] binAddrT;

    // pixel currently owning the window
    typedef logic [`PIXEL_W-1:0] pixelIdxT;

    // one histogram bin count
    typedef logic [`COUNT_W-1:0] countT;

    // cycle position inside a window, 0 .. ACQ_LEN-1
    typedef logic [$clog2(`ACQ_LEN)-1:0] acqCntT;

endpackage

// File: histogram_config.svh
`ifndef HISTOGRAM_CONFIG_SVH
`define HISTOGRAM_CONFIG_SVH

// bins per pixel and bin address width
`define BIN_NUM 16
`define BIN_W 4

// pixels served one after another by the window counter
`define PIXEL_NUM 4
`define PIXEL_W 2

// clock cycles each pixel gets per acquisition window
`define ACQ_LEN 64

// width of one bin counter, saturates at all ones
`define COUNT_W 8

`endif
